/* list.f */
hdl/ep_pkg.sv
hdl/ep_client_port.sv
hdl/ep_irq_ctrl.sv
hdl/ep_token_arb.sv
hdl/ep_out_stage.sv
hdl/ep_arb_top.sv
dv/ep_arb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the endpoint arbiter testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module ep_arb_tb -o ep_arb_sim
./obj_dir/ep_arb_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

/* dv/ep_arb_tb.sv */
/*
 * Testbench for ep_arb_top with FIFO_DEPTH 8 and IRQ_W 4.
 * rx/tx packets stay at 5 beats or less so a port always completes them.
 * An irq bit is raised only while the model holds it clear, so each raise
 * maps to exactly one message.
 */
`timescale 1ns/1ps

module ep_arb_tb;
    import ep_pkg::*;

    localparam int TMO = 2000;  // cycles allowed per wait

    logic        clk;
    logic        rst;
    ep_beat_t    rx_in, tx_in, ep_out;
    logic        rx_in_valid, rx_in_ready, tx_in_valid, tx_in_ready;
    logic [3:0]  irq_event;
    logic        ep_out_valid;
    logic        ep_out_ready = 1'b0;
    logic        hold_ready;               // endpoint stalled on purpose
    logic [31:0] rng;                      // stimulus random state
    logic [31:0] rng_ep = 32'h1340;        // endpoint ready random state
    logic [3:0]  raised = '0;              // model of the pending irq vector
    int          err_seq, err_mon, err_prop;
    int          n_raised = 0;
    int          n_seen = 0;
    ep_beat_t    rx_q [$];                 // expected beats, push order
    ep_beat_t    tx_q [$];
    client_id_t  pkt_order [$];            // src of each finished packet
    logic        pkt_open = 1'b0;          // inside a multi-beat packet
    client_id_t  open_src;
    ep_beat_t    out_prev;                 // ep_out one cycle back
    ep_beat_t    out_cur;                  // ep_out this cycle
    logic        valid_cur = 1'b0;

    ep_arb_top #(.IRQ_W(4), .FIFO_DEPTH(8)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #2000000;
        $display("watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    always @(posedge clk) begin
        #1;
        rng_ep       = xorshift(rng_ep);
        ep_out_ready = !hold_ready && (rng_ep[1:0] != 2'b00);  // ~75% ready
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic send_packet(input client_id_t cli, input int len);
        ep_beat_t b;
        int       waited;
        for (int i = 0; i < len; i++) begin
            rng    = xorshift(rng);
            b.data = {rng, 8'(cli), 24'(i)};  // tagged by client and index
            b.last = (i == len - 1);
            b.src  = cli;
            if (cli == CLI_RX) begin
                rx_in       = b;
                rx_in_valid = 1'b1;
            end else begin
                tx_in       = b;
                tx_in_valid = 1'b1;
            end
            waited = 0;
            // ready is registered, so mid-cycle value decides the next edge
            while (!(cli == CLI_RX ? rx_in_ready : tx_in_ready) && waited < TMO) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (waited >= TMO) begin
                $display("client port %0d never accepted beat %0d", cli, i);
                err_seq++;
            end else if (cli == CLI_RX) begin
                rx_q.push_back(b);
            end else begin
                tx_q.push_back(b);
            end
            @(posedge clk);
            #1;
        end
        rx_in_valid = (cli == CLI_RX) ? 1'b0 : rx_in_valid;
        tx_in_valid = (cli == CLI_TX) ? 1'b0 : tx_in_valid;
    endtask

    //////////////////////////////////////////////////
    // scoreboard, mid-cycle so every value is settled
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        ep_beat_t e;
        e = '0;
        if (!rst && ep_out_valid && ep_out_ready) begin
            if (pkt_open) begin
                chk_mix: assert (ep_out.src == open_src) else begin
                    $display("FAIL no_interleave expected src %0d actual src %0d",
                             open_src, ep_out.src);
                    err_mon++;
                end
            end
            if (ep_out.src == CLI_IRQ) begin
                chk_irq: assert (ep_out.data[3:0] != '0 && ep_out.data[63:4] == '0
                                 && (ep_out.data[3:0] & ~raised) == '0)
                    else begin
                        $display("FAIL irq_coverage expected subset of %h actual %h",
                                 raised, ep_out.data);
                        err_mon++;
                    end
                raised = raised & ~ep_out.data[3:0];  // these events are delivered
                n_seen += $countones(ep_out.data[3:0]);
            end else if (ep_out.src == CLI_RX ? rx_q.size() == 0 : tx_q.size() == 0) begin
                $display("beat from src %0d on ep_out was never pushed", ep_out.src);
                err_mon++;
            end else begin
                if (ep_out.src == CLI_RX) begin
                    e = rx_q.pop_front();
                end else begin
                    e = tx_q.pop_front();
                end
                chk_beat: assert ({ep_out.data, ep_out.last} == {e.data, e.last})
                    else begin
                        $display("FAIL packet_integrity expected %h/%b actual %h/%b",
                                 e.data, e.last, ep_out.data, ep_out.last);
                        err_mon++;
                    end
            end
            if (ep_out.last) begin
                pkt_order.push_back(ep_out.src);
            end
            pkt_open = !ep_out.last;
            open_src = ep_out.src;
        end
        raised = raised | irq_event;  // sampled by the dut at the next edge
        n_raised += $countones(irq_event);
        out_prev  = out_cur;  // trace for the stall report
        out_cur   = ep_out;
        valid_cur = ep_out_valid;
    end

    // stalled output holds still
    hold_a: assert property (@(posedge clk) disable iff (rst)
        ep_out_valid && !ep_out_ready |=> ep_out_valid && ep_out == $past(ep_out))
        else begin
            $display("FAIL backpressure expected valid 1 beat %h actual valid %b beat %h",
                     out_prev, valid_cur, out_cur);
            err_prop++;
        end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        int waited;
        int r_len;
        int t_len;
        rst         = 1'b1;
        rx_in       = '0;
        tx_in       = '0;
        rx_in_valid = 1'b0;
        tx_in_valid = 1'b0;
        irq_event   = '0;
        hold_ready  = 1'b1;
        rng         = 32'h1340;
        err_seq     = 0;
        err_mon     = 0;
        err_prop    = 0;
        repeat (3) begin
            @(posedge clk);
            #1;
            assert (!ep_out_valid) else begin
                $display("FAIL reset_state expected ep_out_valid 0 actual %b", ep_out_valid);
                err_seq++;
            end
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        assert (!ep_out_valid && rx_in_ready && tx_in_ready) else begin
            $display("FAIL reset_state expected valid/rx/tx 011 actual %b%b%b",
                     ep_out_valid, rx_in_ready, tx_in_ready);
            err_seq++;
        end

        // first rx packet of 3 beats stalls in the output stage with drvn high
        send_packet(CLI_RX, 3);
        send_packet(CLI_RX, 2);
        send_packet(CLI_RX, 1);
        send_packet(CLI_RX, 2);
        send_packet(CLI_TX, 2);
        send_packet(CLI_TX, 1);
        send_packet(CLI_TX, 3);
        send_packet(CLI_TX, 2);
        hold_ready = 1'b0;
        waited = 0;
        while (pkt_order.size() < 8 && waited < TMO) begin
            @(posedge clk);
            waited++;
        end
        for (int i = 0; i < 8 && i < pkt_order.size(); i++) begin
            assert (pkt_order[i] == (i % 2 == 1 ? CLI_TX : CLI_RX)) else begin
                $display("FAIL alternation expected src %0d actual src %0d",
                         i % 2, pkt_order[i]);
                err_seq++;
            end
        end
        if (waited >= TMO) begin
            $display("only %0d preloaded packets reached ep_out", pkt_order.size());
            err_seq++;
        end

        // mixed traffic with interrupts
        #1;
        fork
            for (int p = 0; p < 25; p++) begin
                rng   = xorshift(rng);
                r_len = 1 + int'(rng % 5);
                send_packet(CLI_RX, r_len);
            end
            for (int p = 0; p < 25; p++) begin
                rng   = xorshift(rng);
                t_len = 1 + int'(rng % 5);
                send_packet(CLI_TX, t_len);
            end
            repeat (500) begin
                rng       = xorshift(rng);
                irq_event = (rng[10:8] == 3'b000) ? (rng[3:0] & ~raised) : '0;  // one-cycle pulse
                @(posedge clk);
                #1;
            end
        join
        irq_event = '0;
        waited = 0;
        while ((rx_q.size() != 0 || tx_q.size() != 0 || raised != '0) && waited < TMO) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= TMO) begin
            $display("traffic did not drain: rx %0d tx %0d beats, irq bits %h left",
                     rx_q.size(), tx_q.size(), raised);
            err_seq++;
        end
        assert (n_raised == n_seen) else begin
            $display("FAIL irq_count expected %0d actual %0d", n_raised, n_seen);
            err_seq++;
        end

        $display("errors: sequence %0d scoreboard %0d properties %0d, irq bits %0d",
                 err_seq, err_mon, err_prop, n_seen);
        if (err_seq + err_mon + err_prop == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/ep_arb_top.sv */
/*
 * Endpoint transmit arbiter top level.
 * rx and tx push ready-made packets; irq_event lines are level inputs
 * sampled every cycle. Latency to ep_out depends on arbitration and
 * back-pressure, so ep_out_valid is the only timing reference.
 */
`timescale 1ns/1ps

module ep_arb_top #(
    parameter int IRQ_W      = ep_pkg::IRQ_W,
    parameter int FIFO_DEPTH = ep_pkg::FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  ep_pkg::ep_beat_t rx_in,
    input  logic             rx_in_valid,
    output logic             rx_in_ready,
    input  ep_pkg::ep_beat_t tx_in,
    input  logic             tx_in_valid,
    output logic             tx_in_ready,
    input  logic [IRQ_W-1:0] irq_event,
    output ep_pkg::ep_beat_t ep_out,
    output logic             ep_out_valid,
    input  logic             ep_out_ready
);
    import ep_pkg::*;

    // arbiter handshake
    logic     rx_turn, rx_drvn;
    logic     tx_turn, tx_drvn;
    logic     irq_turn, irq_drvn, irq_reqep;

    // client streams into the output stage
    ep_beat_t rx_beat, tx_beat, irq_beat;
    logic     rx_valid, tx_valid, irq_valid;
    logic     rx_ready, tx_ready, irq_ready;

    ep_client_port #(.CLIENT(CLI_RX), .FIFO_DEPTH(FIFO_DEPTH)) rx_port_i (
        .clk, .rst,
        .in_beat(rx_in), .in_valid(rx_in_valid), .in_ready(rx_in_ready),
        .turn(rx_turn), .drvn(rx_drvn),
        .out_beat(rx_beat), .out_valid(rx_valid), .out_ready(rx_ready)
    );

    ep_client_port #(.CLIENT(CLI_TX), .FIFO_DEPTH(FIFO_DEPTH)) tx_port_i (
        .clk, .rst,
        .in_beat(tx_in), .in_valid(tx_in_valid), .in_ready(tx_in_ready),
        .turn(tx_turn), .drvn(tx_drvn),
        .out_beat(tx_beat), .out_valid(tx_valid), .out_ready(tx_ready)
    );

    ep_irq_ctrl #(.IRQ_W(IRQ_W)) irq_i (
        .clk, .rst, .irq_event,
        .turn(irq_turn), .drvn(irq_drvn), .reqep(irq_reqep),
        .out_beat(irq_beat), .out_valid(irq_valid), .out_ready(irq_ready)
    );

    ep_token_arb arb_i (
        .clk, .rst,
        .rx_turn, .rx_drvn, .tx_turn, .tx_drvn,
        .irq_turn, .irq_drvn, .irq_reqep
    );

    ep_out_stage out_i (
        .clk, .rst,
        .rx_beat, .rx_valid, .rx_ready,
        .tx_beat, .tx_valid, .tx_ready,
        .irq_beat, .irq_valid, .irq_ready,
        .ep_out, .ep_out_valid, .ep_out_ready
    );

endmodule

/* hdl/ep_out_stage.sv */
/*
 * Merge and output register toward the endpoint.
 * Relies on the arbiter so that at most one client input is valid.
 * Output register plus one skid entry hold two beats under back-pressure.
 * Client ready is a register and never a path from ep_out_ready.
 */
`timescale 1ns/1ps

module ep_out_stage (
    input  logic             clk,
    input  logic             rst,
    input  ep_pkg::ep_beat_t rx_beat,
    input  logic             rx_valid,
    output logic             rx_ready,
    input  ep_pkg::ep_beat_t tx_beat,
    input  logic             tx_valid,
    output logic             tx_ready,
    input  ep_pkg::ep_beat_t irq_beat,
    input  logic             irq_valid,
    output logic             irq_ready,
    output ep_pkg::ep_beat_t ep_out,
    output logic             ep_out_valid,
    input  logic             ep_out_ready
);
    import ep_pkg::*;

    ep_beat_t in_beat;     // selected client beat
    logic     in_valid;
    logic     in_ready;    // shared ready, registered
    ep_beat_t skid;
    logic     skid_valid;
    logic     skid_valid_nxt;
    logic     acc;
    logic     load;        // output register free this cycle

    assign in_valid = rx_valid || tx_valid || irq_valid;
    assign in_beat  = rx_valid ? rx_beat : (tx_valid ? tx_beat : irq_beat);
    assign acc      = in_valid && in_ready;
    assign load     = !ep_out_valid || ep_out_ready;

    // skid fills only when output is stalled, drains into output on load
    assign skid_valid_nxt = load ? 1'b0 : (skid_valid || acc);

    always_ff @(posedge clk) begin
        if (rst) begin
            ep_out_valid <= 1'b0;
            skid_valid   <= 1'b0;
            in_ready     <= 1'b0;
        end else begin
            if (load) begin
                ep_out_valid <= skid_valid || acc;
            end
            skid_valid <= skid_valid_nxt;
            in_ready   <= !skid_valid_nxt;  // space left for one beat
        end
    end

    ///////////////////////////////////////////////////
    // payload
    always_ff @(posedge clk) begin
        if (load && skid_valid) begin
            ep_out <= skid;
        end else if (load && acc) begin
            ep_out <= in_beat;
        end else if (acc) begin
            skid <= in_beat;  // output stalled, park here
        end
    end

    assign rx_ready  = in_ready;
    assign tx_ready  = in_ready;
    assign irq_ready = in_ready;

endmodule

/* hdl/ep_token_arb.sv */
/*
 * Token arbiter for the shared endpoint transmit stream.
 * rx and tx get alternate turns, rx first after reset.
 * irq is slotted in after a dma turn when it requests and both dma
 * clients are idle. Turns are one-cycle registered pulses; a client
 * that has nothing to send lets its turn pass.
 */
`timescale 1ns/1ps

module ep_token_arb (
    input  logic clk,
    input  logic rst,
    output logic rx_turn,
    input  logic rx_drvn,
    output logic tx_turn,
    input  logic tx_drvn,
    output logic irq_turn,
    input  logic irq_drvn,
    input  logic irq_reqep
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,  // wait for a free stream
        POST     = 2'd1,  // dma turn just issued
        IRQ_WAIT = 2'd2,  // wait for dma clients to go quiet
        IRQ_POST = 2'd3   // irq turn just issued
    } arb_state_t;

    arb_state_t state;
    logic       turn_bit;  // 0 gives rx the next turn

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            turn_bit <= 1'b0;
            rx_turn  <= 1'b0;
            tx_turn  <= 1'b0;
            irq_turn <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!rx_drvn && !tx_drvn && !irq_drvn) begin
                        turn_bit <= ~turn_bit;
                        if (!turn_bit) begin
                            rx_turn <= 1'b1;
                        end else begin
                            tx_turn <= 1'b1;
                        end
                        state <= POST;
                    end
                end
                POST: begin
                    rx_turn <= 1'b0;  // one-cycle pulse
                    tx_turn <= 1'b0;
                    state   <= irq_reqep ? IRQ_WAIT : IDLE;
                end
                IRQ_WAIT: begin
                    if (!rx_drvn && !tx_drvn) begin
                        irq_turn <= 1'b1;
                        state    <= IRQ_POST;
                    end
                end
                IRQ_POST: begin
                    irq_turn <= 1'b0;
                    state    <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/ep_irq_ctrl.sv */
/*
 * Interrupt collector and message sender.
 * Event lines are ORed into a pending vector every cycle.
 * One message carries a snapshot of that vector in its low IRQ_W data bits.
 * Events arriving while a message waits stay pending for the next one.
 */
`timescale 1ns/1ps

module ep_irq_ctrl #(
    parameter int IRQ_W = ep_pkg::IRQ_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [IRQ_W-1:0] irq_event,
    input  logic             turn,
    output logic             drvn,
    output logic             reqep,
    output ep_pkg::ep_beat_t out_beat,
    output logic             out_valid,
    input  logic             out_ready
);
    import ep_pkg::*;

    logic [IRQ_W-1:0] pending;  // events not yet sent
    logic [IRQ_W-1:0] snap;     // vector in flight
    logic             take;

    assign take = turn && !drvn && (pending != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            drvn    <= 1'b0;
        end else if (take) begin
            pending <= irq_event;  // snapped bits cleared, new ones kept
            drvn    <= 1'b1;
        end else begin
            pending <= pending | irq_event;
            if (drvn && out_ready) begin
                drvn <= 1'b0;  // message accepted
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            snap <= pending;
        end
    end

    // single-beat message
    always_comb begin
        out_beat.data = EP_DATA_W'(snap);  // zero extended
        out_beat.last = 1'b1;
        out_beat.src  = CLI_IRQ;
    end

    assign out_valid = drvn;
    assign reqep     = (pending != '0) && !drvn;

endmodule

/* hdl/ep_client_port.sv */
/*
 * Per-client packet queue in front of the token arbiter.
 * Only whole packets are sent, so a turn is taken only once the last
 * beat of at least one packet has been written.
 * A turn that arrives with no complete packet is dropped.
 * in_ready is registered and stays low while in reset.
 */
`timescale 1ns/1ps

module ep_client_port #(
    parameter ep_pkg::client_id_t CLIENT     = ep_pkg::CLI_RX,
    parameter int                 FIFO_DEPTH = ep_pkg::FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  ep_pkg::ep_beat_t in_beat,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic             turn,
    output logic             drvn,
    output ep_pkg::ep_beat_t out_beat,
    output logic             out_valid,
    input  logic             out_ready
);
    import ep_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    ep_beat_t      mem [FIFO_DEPTH];  // beat storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   cnt;               // beats held
    logic [AW:0]   cnt_nxt;
    logic [AW:0]   pkt_cnt;           // complete packets held
    logic          wr;
    logic          rd;

    assign wr      = in_valid && in_ready;
    assign rd      = out_valid && out_ready;
    assign cnt_nxt = cnt + (AW+1)'(wr) - (AW+1)'(rd);

    // storage write
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            pkt_cnt  <= '0;
            in_ready <= 1'b0;
            drvn     <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt      <= cnt_nxt;
            in_ready <= (cnt_nxt != (AW+1)'(FIFO_DEPTH));  // room for one more
            pkt_cnt  <= pkt_cnt + (AW+1)'(wr && in_beat.last)
                                - (AW+1)'(rd && out_beat.last);
            // take the turn only with a whole packet queued
            if (!drvn && turn && (pkt_cnt != '0)) begin
                drvn <= 1'b1;
            end else if (rd && out_beat.last) begin
                drvn <= 1'b0;  // release after last beat
            end
        end
    end

    // head of queue, stamped with this client's id
    always_comb begin
        out_beat     = mem[rd_ptr];
        out_beat.src = CLIENT;
    end

    assign out_valid = drvn;  // whole packet is already queued

endmodule

/* hdl/ep_pkg.sv */
/*
 * Shared types for the PCIe endpoint transmit arbiter.
 * All client streams carry ep_beat_t. src is set by the sending block,
 * so any src value arriving on a client input is ignored.
 * IRQ_W and FIFO_DEPTH here are only defaults; the top level passes its own.
 * IRQ_W works for 1 to 32, FIFO_DEPTH for powers of two from 4 to 64.
 */
package ep_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    parameter int EP_DATA_W  = 64;  // data bits per beat
    parameter int IRQ_W      = 4;   // interrupt event lines
    parameter int FIFO_DEPTH = 8;   // client port depth in beats

    //////////////////////////////////////////////////
    // client identifiers
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        CLI_RX  = 2'd0,  // receive-side dma
        CLI_TX  = 2'd1,  // transmit-side dma
        CLI_IRQ = 2'd2   // interrupt controller
    } client_id_t;

    //////////////////////////////////////////////////
    // one beat toward the endpoint
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [EP_DATA_W-1:0] data;
        logic                 last;  // end of packet
        client_id_t           src;   // originating client
    } ep_beat_t;

endpackage
